/* sgmii_tx_pkg.sv */
package sgmii_tx_pkg;

    // FIFO sizing. The depth is also the credit count a source owns after reset.
    localparam int BUF_DEPTH       = 16;
    localparam int BUF_START_LEVEL = 4;                     // Occupancy that starts a drain.
    localparam int BUF_PTR_W       = $clog2(BUF_DEPTH);
    localparam int BUF_CNT_W       = $clog2(BUF_DEPTH + 1); // Count must reach BUF_DEPTH.

    // Autonegotiation link timer, in tbi_tx_clk cycles.
    localparam int AN_LINK_TIMER = 1000;
    localparam int AN_TIMER_W    = $clog2(AN_LINK_TIMER + 1);

    // Symbol byte codes ahead of the 8b/10b encoder.
    localparam logic [7:0] K28_5 = 8'hBC;                   // Comma, first byte of every set.
    localparam logic [7:0] D21_5 = 8'hB5;                   // Second byte of /C1/.
    localparam logic [7:0] D2_2  = 8'h42;                   // Second byte of /C2/.
    localparam logic [7:0] D16_2 = 8'h50;                   // Second byte of /I2/.
    localparam logic [7:0] K30_7 = 8'hFE;                   // Error propagation.

    // One GMII transmit cycle.
    typedef struct packed {
        logic [7:0] txd;
        logic       tx_en;
        logic       tx_err;
    } gmii_tx_t;

    // One symbol toward the encoder.
    typedef struct packed {
        logic [7:0] data;
        logic       is_k;
    } tx_sym_t;

    // Head of the byte buffer as offered to the mux.
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       err;
    } buf_out_t;

    // SGMII configuration word, MSB first.
    typedef struct packed {
        logic       link_up;
        logic       ack;
        logic       reserved_13;
        logic       duplex;
        logic [1:0] speed;                                  // 2'b10 is 1000 Mb/s.
        logic [8:0] reserved_9_1;
        logic       sgmii_sel;
    } cfg_fields_t;

    // The same word seen as fields by the generator and as two bytes on the wire.
    typedef union packed {
        cfg_fields_t fields;
        logic [15:0] raw;
    } cfg_word_u;

    // Link up, full duplex, 1000 Mb/s, SGMII. The ack bit is added at run time.
    localparam cfg_fields_t CFG_BASE = '{
        link_up:      1'b1,
        ack:          1'b0,
        reserved_13:  1'b0,
        duplex:       1'b1,
        speed:        2'b10,
        reserved_9_1: 9'd0,
        sgmii_sel:    1'b1
    };

endpackage

/* sgmii_tx_buf.sv */
`timescale 1ns/1ps

module sgmii_tx_buf (
    input  logic                   tbi_tx_clk,
    input  logic                   tbi_tx_rdy,
    input  sgmii_tx_pkg::gmii_tx_t gmii,
    input  logic                   pop,
    output sgmii_tx_pkg::buf_out_t head,
    output logic                   credit_return
);
    import sgmii_tx_pkg::*;

    // Stored payload of one GMII cycle.
    typedef struct packed {
        logic       err;
        logic [7:0] data;
    } buf_entry_t;

    buf_entry_t           mem [BUF_DEPTH];
    logic [BUF_PTR_W-1:0] wr_ptr;
    logic [BUF_PTR_W-1:0] rd_ptr;
    logic [BUF_CNT_W-1:0] count;
    logic [BUF_CNT_W-1:0] count_nxt;
    logic                 draining;
    logic                 push;
    logic                 pop_ok;

    // The credit scheme guarantees room for every enabled cycle.
    assign push   = gmii.tx_en;
    assign pop_ok = pop && head.valid;                      // A stray pop is ignored.

    // Storage array, written at the edge where tx_en is high.
    always_ff @(posedge tbi_tx_clk) begin
        if (push) begin
            mem[wr_ptr] <= '{err: gmii.tx_err, data: gmii.txd};
        end
    end

    always_ff @(posedge tbi_tx_clk or negedge tbi_tx_rdy) begin
        if (!tbi_tx_rdy) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;                    // Depth is a power of two.
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy after this cycle's push and pop.
    always_comb begin
        count_nxt = count;
        if (push && !pop_ok) begin
            count_nxt = count + 1'b1;
        end else if (pop_ok && !push) begin
            count_nxt = count - 1'b1;
        end
    end

    always_ff @(posedge tbi_tx_clk or negedge tbi_tx_rdy) begin
        if (!tbi_tx_rdy) begin
            count <= '0;
        end else begin
            count <= count_nxt;
        end
    end

    // Start hysteresis: hold bytes until the threshold, then drain to empty.
    always_ff @(posedge tbi_tx_clk or negedge tbi_tx_rdy) begin
        if (!tbi_tx_rdy) begin
            draining <= 1'b0;
        end else if (count_nxt == '0) begin
            draining <= 1'b0;
        end else if (count_nxt >= BUF_CNT_W'(BUF_START_LEVEL)) begin
            draining <= 1'b1;
        end
    end

    // Each consumed byte hands one credit back, a cycle after the pop.
    always_ff @(posedge tbi_tx_clk or negedge tbi_tx_rdy) begin
        if (!tbi_tx_rdy) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop_ok;
        end
    end

    always_comb begin
        head.valid = draining && (count != '0);
        head.data  = mem[rd_ptr].data;
        head.err   = mem[rd_ptr].err;                       // Payload is only meaningful with valid.
    end

endmodule

/* sgmii_autoneg_gen.sv */
`timescale 1ns/1ps

module sgmii_autoneg_gen (
    input  logic                  tbi_tx_clk,
    input  logic                  tbi_tx_rdy,
    input  logic                  autoneg_start,
    input  logic                  autoneg_ack,
    output sgmii_tx_pkg::tx_sym_t an_sym
);
    import sgmii_tx_pkg::*;

    logic [2:0]            seq;                             // Position of the symbol on an_sym.
    logic [2:0]            seq_nxt;
    logic [AN_TIMER_W-1:0] link_timer;
    logic                  timer_done;
    cfg_word_u             cfg;

    // Symbol at one position of the /C1/ /C2/ pair of ordered sets.
    function automatic tx_sym_t seq_sym(input logic [2:0] pos, input cfg_word_u word);
        tx_sym_t sym;
        case (pos)
            3'd0: sym = '{data: K28_5, is_k: 1'b1};
            3'd1: sym = '{data: D21_5, is_k: 1'b0};
            3'd4: sym = '{data: K28_5, is_k: 1'b1};
            3'd5: sym = '{data: D2_2, is_k: 1'b0};
            3'd2,
            3'd6: sym = '{data: word.raw[7:0], is_k: 1'b0};
            default: sym = '{data: word.raw[15:8], is_k: 1'b0};
        endcase
        return sym;
    endfunction

    // The timer runs while autoneg_start is held and saturates at the limit.
    always_ff @(posedge tbi_tx_clk or negedge tbi_tx_rdy) begin
        if (!tbi_tx_rdy) begin
            link_timer <= '0;
        end else if (!autoneg_start) begin
            link_timer <= '0;
        end else if (!timer_done) begin
            link_timer <= link_timer + 1'b1;
        end
    end

    assign timer_done = (link_timer == AN_TIMER_W'(AN_LINK_TIMER));

    // A zero word until the link timer expires.
    always_comb begin
        cfg.raw = '0;
        if (timer_done) begin
            cfg.fields     = CFG_BASE;
            cfg.fields.ack = autoneg_ack;
        end
    end

    assign seq_nxt = seq + 3'd1;

    // The tx reset value stands in for position 0, so this stage starts at position 1.
    always_ff @(posedge tbi_tx_clk or negedge tbi_tx_rdy) begin
        if (!tbi_tx_rdy) begin
            seq    <= 3'd1;
            an_sym <= '{data: D21_5, is_k: 1'b0};
        end else begin
            seq    <= seq_nxt;                              // Wraps after the /C2/ set.
            an_sym <= seq_sym(seq_nxt, cfg);
        end
    end

endmodule

/* sgmii_tx_mux.sv */
`timescale 1ns/1ps

module sgmii_tx_mux (
    input  logic                   tbi_tx_clk,
    input  logic                   tbi_tx_rdy,
    input  logic                   autoneg_done,
    input  sgmii_tx_pkg::tx_sym_t  an_sym,
    input  sgmii_tx_pkg::buf_out_t head,
    output logic                   pop,
    output sgmii_tx_pkg::tx_sym_t  tx
);
    import sgmii_tx_pkg::*;

    tx_sym_t sel;
    logic    idle_second;                                   // Next symbol closes an idle pair.
    logic    idle_second_nxt;

    always_comb begin
        sel             = an_sym;
        pop             = 1'b0;
        idle_second_nxt = 1'b0;
        if (autoneg_done) begin
            if (idle_second) begin
                sel = '{data: D16_2, is_k: 1'b0};
            end else if (head.valid) begin
                pop = 1'b1;
                if (head.err) begin
                    sel = '{data: K30_7, is_k: 1'b1};       // Error byte replaces the data.
                end else begin
                    sel = '{data: head.data, is_k: 1'b0};
                end
            end else begin
                // Nothing ready, so open an /I2/ pair.
                sel             = '{data: K28_5, is_k: 1'b1};
                idle_second_nxt = 1'b1;
            end
        end
    end

    always_ff @(posedge tbi_tx_clk or negedge tbi_tx_rdy) begin
        if (!tbi_tx_rdy) begin
            tx          <= '{data: K28_5, is_k: 1'b1};
            idle_second <= 1'b0;
        end else begin
            tx          <= sel;
            idle_second <= idle_second_nxt;
        end
    end

endmodule

/* sgmii_tx_top.sv */
`timescale 1ns/1ps

module sgmii_tx_top (
    input  logic                   tbi_tx_clk,
    input  logic                   tbi_tx_rdy,
    input  sgmii_tx_pkg::gmii_tx_t gmii,
    input  logic                   autoneg_start,
    input  logic                   autoneg_ack,
    input  logic                   autoneg_done,
    output logic                   credit_return,
    output sgmii_tx_pkg::tx_sym_t  tx
);
    import sgmii_tx_pkg::*;

    buf_out_t head;                                         // Buffer head toward the mux.
    logic     pop;
    tx_sym_t  an_sym;                                       // Configuration stream.

    sgmii_tx_buf u_buf (
        .tbi_tx_clk    (tbi_tx_clk),
        .tbi_tx_rdy    (tbi_tx_rdy),
        .gmii          (gmii),
        .pop           (pop),
        .head          (head),
        .credit_return (credit_return)
    );

    sgmii_autoneg_gen u_autoneg_gen (
        .tbi_tx_clk    (tbi_tx_clk),
        .tbi_tx_rdy    (tbi_tx_rdy),
        .autoneg_start (autoneg_start),
        .autoneg_ack   (autoneg_ack),
        .an_sym        (an_sym)
    );

    sgmii_tx_mux u_mux (
        .tbi_tx_clk   (tbi_tx_clk),
        .tbi_tx_rdy   (tbi_tx_rdy),
        .autoneg_done (autoneg_done),
        .an_sym       (an_sym),
        .head         (head),
        .pop          (pop),
        .tx           (tx)
    );

endmodule

/* tb_sgmii_tx_checker.sv */
`timescale 1ns/1ps

module tb_sgmii_tx_checker (
    input logic                  tbi_tx_clk,
    input logic                  tbi_tx_rdy,
    input logic                  autoneg_done,
    input sgmii_tx_pkg::tx_sym_t tx
);
    import sgmii_tx_pkg::*;

    tx_sym_t     exp_q [$];                                 // Bytes pushed but not yet seen.
    string       test_name = "reset";
    logic        an_active = 1'b0;
    logic [15:0] an_cfg = '0;
    int          an_skip = 0;
    int          test_errors = 0;
    int          test_symbols = 0;
    int          error_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic [2:0]  pos;                                       // Sequence position shown on tx.
    logic        done_seen;
    logic        idle_open = 1'b0;                          // A comma has opened an /I2/ pair.

    task automatic start_test(input string name, input logic data_phase,
                              input logic [15:0] cfg);
        test_name    = name;
        an_active    = !data_phase;
        an_cfg       = cfg;
        an_skip      = 8;                                   // One sequence period to settle.
        test_errors  = 0;
        test_symbols = 0;
    endtask

    task automatic expect_symbol(input tx_sym_t sym);
        exp_q.push_back(sym);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic end_test();
        an_active = 1'b0;
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %s: ok, %0d symbols checked", test_name, test_symbols);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", test_name, test_errors);
        end
    endtask

    task automatic flag(input string text);
        $display("%s", text);
        test_errors++;
        error_count++;
    endtask

    function automatic string mismatch_text(input string what, input tx_sym_t exp_sym);
        return $sformatf("Mismatch in %s (%s): expected %h k=%b, actual %h k=%b",
                         test_name, what, exp_sym.data, exp_sym.is_k, tx.data, tx.is_k);
    endfunction

    // /C1/ then /C2/, each a comma, its own data code and the word low byte first.
    function automatic tx_sym_t cfg_stream_sym(input logic [2:0] p, input logic [15:0] w);
        case (p[1:0])
            2'd0:    return '{data: K28_5, is_k: 1'b1};
            2'd1:    return '{data: p[2] ? D2_2 : D21_5, is_k: 1'b0};
            2'd2:    return '{data: w[7:0], is_k: 1'b0};
            default: return '{data: w[15:8], is_k: 1'b0};
        endcase
    endfunction

    always @(posedge tbi_tx_clk or negedge tbi_tx_rdy) begin
        if (!tbi_tx_rdy) begin
            pos       <= 3'd0;
            done_seen <= 1'b0;
        end else begin
            pos       <= pos + 3'd1;
            done_seen <= autoneg_done;                      // Mode that picked the next tx.
        end
    end

    always @(negedge tbi_tx_clk) begin
        tx_sym_t exp_sym;
        if (!tbi_tx_rdy || !done_seen) begin
            idle_open = 1'b0;
        end
        if (tbi_tx_rdy && !done_seen && an_active) begin
            if (an_skip > 0) begin
                an_skip--;
            end else begin
                exp_sym = cfg_stream_sym(pos, an_cfg);
                test_symbols++;
                if (tx !== exp_sym) begin
                    flag(mismatch_text("config", exp_sym));
                end
            end
        end else if (tbi_tx_rdy && done_seen) begin
            if (idle_open) begin
                idle_open = 1'b0;
                exp_sym   = '{data: D16_2, is_k: 1'b0};
                if (tx !== exp_sym) begin
                    flag(mismatch_text("idle pair", exp_sym));
                end
            end else if (tx.is_k && tx.data == K28_5) begin
                idle_open = 1'b1;
            end else if (tx.is_k && tx.data != K30_7) begin
                flag($sformatf("Error in %s: unexpected K symbol %h", test_name, tx.data));
            end else if (exp_q.size() == 0) begin
                flag($sformatf("Error in %s: symbol %h arrived with no byte outstanding",
                               test_name, tx.data));
            end else begin
                exp_sym = exp_q.pop_front();
                test_symbols++;
                if (tx !== exp_sym) begin
                    flag(mismatch_text("data", exp_sym));
                end
            end
        end
    end

endmodule

/* tb_sgmii_tx_assertions.sv */
`timescale 1ns/1ps

module tb_sgmii_tx_assertions (
    input logic                   tbi_tx_clk,
    input logic                   tbi_tx_rdy,
    input sgmii_tx_pkg::gmii_tx_t gmii,
    input logic                   autoneg_done,
    input logic                   pop,
    input logic                   credit_return,
    input sgmii_tx_pkg::tx_sym_t  tx
);
    import sgmii_tx_pkg::*;

    int credits;                                            // Credits the source should hold.
    int fail_count = 0;

    always @(posedge tbi_tx_clk or negedge tbi_tx_rdy) begin
        if (!tbi_tx_rdy) begin
            credits <= BUF_DEPTH;
        end else begin
            credits <= credits - int'(gmii.tx_en) + int'(credit_return);
        end
    end

    push_needs_credit: assert property (@(posedge tbi_tx_clk) disable iff (!tbi_tx_rdy)
        gmii.tx_en |-> credits > 0)
    else begin
        fail_count++;
        $error("Push made with no credit outstanding");
    end

    // A data byte covers D16_2 as well, since neither carries the K flag.
    comma_then_second: assert property (@(posedge tbi_tx_clk) disable iff (!tbi_tx_rdy)
        ($past(autoneg_done) && autoneg_done && tx.is_k && tx.data == K28_5)
        |=> !tx.is_k || (tx.is_k && tx.data == K30_7))
    else begin
        fail_count++;
        $error("K28_5 after autoneg done followed by an illegal symbol");
    end

    // A returned credit needs a byte still outstanding before it is counted back.
    credit_follows_pop: assert property (@(posedge tbi_tx_clk) disable iff (!tbi_tx_rdy)
        credit_return |-> $past(pop) && credits < BUF_DEPTH)
    else begin
        fail_count++;
        $error("Credit returned without a matching pop");
    end

endmodule

bind sgmii_tx_top tb_sgmii_tx_assertions u_assertions (
    .tbi_tx_clk    (tbi_tx_clk),
    .tbi_tx_rdy    (tbi_tx_rdy),
    .gmii          (gmii),
    .autoneg_done  (autoneg_done),
    .pop           (pop),
    .credit_return (credit_return),
    .tx            (tx)
);

/* tb_sgmii_tx.sv */
`timescale 1ns/1ps

module tb_sgmii_tx;
    import sgmii_tx_pkg::*;

    localparam int          NUM_TESTS   = 10;
    localparam int          AN_WINDOW   = 40;               // Cycles watched per autoneg test.
    localparam logic [15:0] CFG_EXPECT  = 16'h9801;         // Link up, full duplex, 1000 Mb/s.
    localparam logic [15:0] CFG_ACK_BIT = 16'h4000;

    typedef struct packed {
        logic        data_phase;
        logic        start;
        logic        ack;
        logic [15:0] exp_cfg;                               // Expected word in autoneg rows.
        int          len;
        int          err_idx;                               // Negative when no byte is bad.
    } test_row_t;

    logic        tbi_tx_clk;
    logic        tbi_tx_rdy;
    gmii_tx_t    gmii;
    logic        autoneg_start;
    logic        autoneg_ack;
    logic        autoneg_done;
    logic        credit_return;
    tx_sym_t     tx;
    test_row_t   rows [NUM_TESTS];
    string       names [NUM_TESTS];
    logic [31:0] lfsr = 32'hbc32;
    int          spent = 0;
    int          returned = 0;
    int          held = 0;                                  // Bytes parked below the start level.
    int          errors = 0;
    int          cycles = 0;
    int          limit = 0;

    sgmii_tx_top uut (
        .tbi_tx_clk    (tbi_tx_clk),
        .tbi_tx_rdy    (tbi_tx_rdy),
        .gmii          (gmii),
        .autoneg_start (autoneg_start),
        .autoneg_ack   (autoneg_ack),
        .autoneg_done  (autoneg_done),
        .credit_return (credit_return),
        .tx            (tx)
    );

    tb_sgmii_tx_checker u_checker (
        .tbi_tx_clk   (tbi_tx_clk),
        .tbi_tx_rdy   (tbi_tx_rdy),
        .autoneg_done (autoneg_done),
        .tx           (tx)
    );

    initial begin
        tbi_tx_clk = 1'b0;
        forever #20 tbi_tx_clk = ~tbi_tx_clk;
    end

    always @(negedge tbi_tx_clk) begin
        if (tbi_tx_rdy && credit_return) begin
            returned++;
        end
    end

    always @(posedge tbi_tx_clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge tbi_tx_clk);
        #2;
    endtask

    // Taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_byte(output logic [7:0] b);
        int i;
        b = '0;
        for (i = 0; i < 8; i++) begin
            lfsr = lfsr_step(lfsr);
            b    = {b[6:0], lfsr[0]};
        end
    endtask

    function automatic int credits_held();
        return BUF_DEPTH - spent + returned;
    endfunction

    task automatic push_byte(input logic [7:0] b, input logic err);
        while (credits_held() == 0) begin
            gmii.tx_en = 1'b0;
            next_cycle();
        end
        gmii = '{txd: b, tx_en: 1'b1, tx_err: err};
        spent++;
        next_cycle();
    endtask

    task automatic set_row(input int idx, input string name, input logic data_phase,
                           input logic start, input logic ack, input logic [15:0] exp_cfg,
                           input int len, input int err_idx);
        names[idx] = name;
        rows[idx]  = '{data_phase: data_phase, start: start, ack: ack, exp_cfg: exp_cfg,
                       len: len, err_idx: err_idx};
    endtask

    task automatic run_autoneg(input int idx);
        int wait_cycles;
        wait_cycles   = (rows[idx].start && !autoneg_start) ? AN_LINK_TIMER : 0;
        autoneg_start = rows[idx].start;
        autoneg_ack   = rows[idx].ack;
        repeat (wait_cycles) next_cycle();
        u_checker.start_test(names[idx], 1'b0, rows[idx].exp_cfg);
        repeat (AN_WINDOW) next_cycle();
        u_checker.end_test();
    endtask

    task automatic run_data(input int idx);
        logic [7:0] b;
        logic       err;
        tx_sym_t    exp_sym;
        int         i;
        if (!autoneg_done) begin
            autoneg_done = 1'b1;
            next_cycle();
        end
        u_checker.start_test(names[idx], 1'b1, 16'h0000);
        for (i = 0; i < rows[idx].len; i++) begin
            take_byte(b);
            err          = (i == rows[idx].err_idx);
            exp_sym.data = err ? K30_7 : b;                 // A bad byte turns into K30.7.
            exp_sym.is_k = err;
            u_checker.expect_symbol(exp_sym);
            push_byte(b, err);
        end
        gmii.tx_en = 1'b0;
        held += rows[idx].len;
        if (held >= BUF_START_LEVEL) begin
            while (u_checker.pending() != 0) begin
                next_cycle();
            end
            held = 0;
        end
        u_checker.end_test();
    endtask

    initial begin
        int total_len;
        int failures;
        int i;
        tbi_tx_rdy    = 1'b0;
        gmii          = '0;
        autoneg_start = 1'b0;
        autoneg_ack   = 1'b0;
        autoneg_done  = 1'b0;
        set_row(0, "an_zero_word", 1'b0, 1'b0, 1'b0, 16'h0000, 0, -1);
        set_row(1, "an_base_word", 1'b0, 1'b1, 1'b0, CFG_EXPECT, 0, -1);
        set_row(2, "an_ack_word", 1'b0, 1'b1, 1'b1, CFG_EXPECT | CFG_ACK_BIT, 0, -1);
        set_row(3, "short_held", 1'b1, 1'b1, 1'b1, 16'h0000, 2, -1);
        set_row(4, "straddle", 1'b1, 1'b1, 1'b1, 16'h0000, 5, -1);
        set_row(5, "mid_error", 1'b1, 1'b1, 1'b1, 16'h0000, 9, 3);
        set_row(6, "long_frame", 1'b1, 1'b1, 1'b1, 16'h0000, 24, -1);
        set_row(7, "at_level", 1'b1, 1'b1, 1'b1, 16'h0000, 4, 0);
        set_row(8, "error_held", 1'b1, 1'b1, 1'b1, 16'h0000, 3, 2);
        set_row(9, "flush", 1'b1, 1'b1, 1'b1, 16'h0000, 6, -1);
        total_len = 0;
        for (i = 0; i < NUM_TESTS; i++) begin
            total_len += rows[i].len;
        end
        limit = 2 * (AN_LINK_TIMER + 4 * total_len) + 200;
        repeat (3) @(posedge tbi_tx_clk);
        #2;
        tbi_tx_rdy = 1'b1;
        for (i = 0; i < NUM_TESTS; i++) begin
            if (rows[i].data_phase) begin
                run_data(i);
            end else begin
                run_autoneg(i);
            end
        end
        repeat (8) next_cycle();                            // Let the last credits come home.
        if (returned != spent || credits_held() != BUF_DEPTH) begin
            errors++;
            $display("Credit error: %0d bytes pushed but %0d credits returned", spent, returned);
        end
        failures = u_checker.error_count + errors + uut.u_assertions.fail_count;
        $display("Summary: %0d tests run, %0d tests failed, %0d errors in total",
                 u_checker.tests_run, u_checker.tests_failed, failures);
        if (failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* project.f */
sgmii_tx_pkg.sv
sgmii_tx_buf.sv
sgmii_autoneg_gen.sv
sgmii_tx_mux.sv
sgmii_tx_top.sv
tb_sgmii_tx_checker.sv
tb_sgmii_tx_assertions.sv
tb_sgmii_tx.sv
